// ==== vlog.f ====
src/dcachePkg.sv
src/cacheWay.sv
src/victimSelect.sv
src/flushScan.sv
src/dcacheController.sv
src/dcache.sv
bench/memModel.sv
bench/dcacheTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dcacheTb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/dcacheTb.sv ====
`timescale 1ns/1ps

module dcacheTb;

	localparam dcachePkg::word_t SEED = 32'h6634;
	localparam int N_ACCESS = 300;
	localparam int CONFLICT_N = 6;
	// Byte addresses below this give eight tags in every set
	localparam int ADDR_SPAN = 512;
	localparam int WAIT_MAX = 3;
	localparam int RESET_CYCLES = 10;
	localparam int MISS_CYCLES = 12;
	localparam int FLUSH_CYCLES = 2 * dcachePkg::SETS * 10 + 8;
	localparam int CYCLE_LIMIT =
		((N_ACCESS + CONFLICT_N) * MISS_CYCLES + FLUSH_CYCLES) * 2 + RESET_CYCLES;

	typedef struct packed {
		logic             wr;
		dcachePkg::word_t addr;
		dcachePkg::word_t data;
	} xfer_t;

	logic CLK = 1'b0;
	logic nRST;
	logic halt;
	logic dHit;
	logic flushed;
	logic memWait;
	logic [1:0] nextWait;
	dcachePkg::cpuReq_t cpuReq;
	dcachePkg::memReq_t memReq;
	dcachePkg::word_t loadData;
	dcachePkg::word_t memLoad;
	dcachePkg::word_t stimState = SEED;
	dcachePkg::word_t waitState = SEED;
	int cycles = 0;
	int logChecked = 0;
	int accessCount = 0;
	int missCount = 0;

	// Shadow of both ways, LRU bits and the flat memory
	dcachePkg::frame_t shadow [2][dcachePkg::SETS];
	logic lastUsed [dcachePkg::SETS];
	dcachePkg::word_t refMem [4096];
	xfer_t expXfer [$];
	dcachePkg::word_t expLoad [$];

	// Set 5 sequence: fill both ways, touch tag 0, then force evictions
	int conflictTag [CONFLICT_N] = '{0, 1, 0, 2, 0, 1};
	logic conflictWr [CONFLICT_N] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};

	dcache DUT (
		.CLK(CLK), .nRST(nRST), .cpuReq(cpuReq), .halt(halt), .dHit(dHit),
		.loadData(loadData), .flushed(flushed), .memReq(memReq),
		.memLoad(memLoad), .memWait(memWait)
	);

	memModel mem (
		.CLK(CLK), .nRST(nRST), .req(memReq), .nextWait(nextWait),
		.load(memLoad), .busy(memWait)
	);

	always #20 CLK = ~CLK;

	task automatic abortRun(input string why);
		$display("TEST FAIL");
		$fatal(1, "%s", why);
	endtask

	function automatic dcachePkg::word_t xorshift(input dcachePkg::word_t s);
		dcachePkg::word_t x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic dcachePkg::word_t memPattern(input dcachePkg::word_t addr);
		return (addr * 32'h9E3779B1) ^ 32'hC3A55A3C;
	endfunction

	function automatic logic [11:0] wordIndex(input dcachePkg::word_t addr);
		return addr[13:2];
	endfunction

	// Both words of a dirty frame go out, word A first
	function void writeBack(input int w, input int i);
		dcachePkg::word_t baseA;
		dcachePkg::word_t baseB;
		baseA = {shadow[w][i].tag, dcachePkg::IDX_W'(i), 3'b000};
		baseB = baseA + 32'd4;
		expXfer.push_back({1'b1, baseA, shadow[w][i].data.wordA});
		expXfer.push_back({1'b1, baseB, shadow[w][i].data.wordB});
		refMem[wordIndex(baseA)] = shadow[w][i].data.wordA;
		refMem[wordIndex(baseB)] = shadow[w][i].data.wordB;
		shadow[w][i].dirty = 1'b0;
	endfunction

	// Reference cache, returns 1 on a predicted hit and the expected load in ld
	function logic refAccess(input dcachePkg::dAddr_t a, input logic wr,
			input dcachePkg::word_t d, output dcachePkg::word_t ld);
		logic hit;
		int w;
		dcachePkg::word_t baseA;
		dcachePkg::word_t baseB;
		hit = 1'b1;
		if (shadow[0][a.idx].valid && shadow[0][a.idx].tag == a.tag) begin
			w = 0;
		end else if (shadow[1][a.idx].valid && shadow[1][a.idx].tag == a.tag) begin
			w = 1;
		end else begin
			hit = 1'b0;
			w = !shadow[0][a.idx].valid ? 0 : !shadow[1][a.idx].valid ? 1 : int'(!lastUsed[a.idx]);
			if (shadow[w][a.idx].valid && shadow[w][a.idx].dirty) begin
				writeBack(w, int'(a.idx));
			end
			baseA = {a.tag, a.idx, 3'b000};
			baseB = baseA + 32'd4;
			shadow[w][a.idx].tag = a.tag;
			shadow[w][a.idx].data.wordA = refMem[wordIndex(baseA)];
			shadow[w][a.idx].data.wordB = refMem[wordIndex(baseB)];
			shadow[w][a.idx].valid = 1'b1;
			shadow[w][a.idx].dirty = 1'b0;
			expXfer.push_back({1'b0, baseA, refMem[wordIndex(baseA)]});
			expXfer.push_back({1'b0, baseB, refMem[wordIndex(baseB)]});
			missCount++;
		end
		if (wr) begin
			if (a.blkOff) begin
				shadow[w][a.idx].data.wordB = d;
			end else begin
				shadow[w][a.idx].data.wordA = d;
			end
			shadow[w][a.idx].dirty = 1'b1;
		end
		ld = a.blkOff ? shadow[w][a.idx].data.wordB : shadow[w][a.idx].data.wordA;
		lastUsed[a.idx] = w[0];
		accessCount++;
		return hit;
	endfunction

	// Way 0 by ascending index, then way 1, then the statistics word
	function void refFlush();
		dcachePkg::word_t stats;
		for (int w = 0; w < 2; w++) begin
			for (int i = 0; i < dcachePkg::SETS; i++) begin
				if (shadow[w][i].dirty) begin
					writeBack(w, i);
				end
			end
		end
		stats = accessCount - missCount;
		expXfer.push_back({1'b1, dcachePkg::STATS_ADDR, stats});
		refMem[wordIndex(dcachePkg::STATS_ADDR)] = stats;
	endfunction

	// Called 2 ns after a rising edge
	task automatic doAccess(input dcachePkg::dAddr_t a, input logic wr,
			input dcachePkg::word_t d);
		dcachePkg::word_t ld;
		logic hit;
		int edges;
		int expEdges;
		hit = refAccess(a, wr, d, ld);
		expLoad.push_back(ld);
		cpuReq.ren = !wr;
		cpuReq.wen = wr;
		cpuReq.addr = a;
		cpuReq.store = d;
		edges = 0;
		do begin
			@(posedge CLK);
			edges++;
			@(negedge CLK);
		end while (!dHit);
		// The request is released at the edge that ends the dHit cycle
		@(posedge CLK);
		edges++;
		#2;
		cpuReq = '0;
		// Write hits pass through OVERWRITE first
		expEdges = wr ? 3 : 2;
		if (hit) begin
			assert (edges == expEdges) else begin
				$display("[ERROR] %0t: hit at 0x%08h took %0d edges, expected %0d",
					$time, a, edges, expEdges);
				abortRun("Hit latency is wrong");
			end
		end else begin
			assert (edges > 3) else begin
				$display("[ERROR] %0t: predicted miss at 0x%08h answered after %0d edges",
					$time, a, edges);
				abortRun("Miss answered as a hit");
			end
		end
	endtask

	always @(posedge CLK) begin
		#2;
		waitState = xorshift(waitState);
		nextWait = 2'(waitState % (WAIT_MAX + 1));
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			abortRun("Timeout, the cache did not finish within the cycle limit");
		end
	end

	// Comparing process
	always @(negedge CLK) begin
		xfer_t got;
		if (nRST && dHit) begin
			assert (expLoad.size() > 0) else abortRun("dHit without an open request");
			assert (loadData == expLoad[0]) else begin
				$display("[ERROR] %0t: load data 0x%08h, expected 0x%08h",
					$time, loadData, expLoad[0]);
				abortRun("Wrong load data");
			end
			void'(expLoad.pop_front());
		end
		while (logChecked < mem.xferLog.size()) begin
			got = xfer_t'(mem.xferLog[logChecked]);
			assert (expXfer.size() > 0) else abortRun("Memory transfer that was not expected");
			assert (got == expXfer[0]) else begin
				$display("[ERROR] %0t: transfer wr=%0b addr=0x%08h data=0x%08h", $time,
					got.wr, got.addr, got.data);
				$display("[ERROR] %0t: expected wr=%0b addr=0x%08h data=0x%08h", $time,
					expXfer[0].wr, expXfer[0].addr, expXfer[0].data);
				abortRun("Wrong memory transfer");
			end
			void'(expXfer.pop_front());
			logChecked++;
		end
	end

	initial begin
		dcachePkg::dAddr_t a;
		logic wr;
		nRST = 1'b0;
		halt = 1'b0;
		cpuReq = '0;
		nextWait = 2'd0;
		for (int i = 0; i < dcachePkg::SETS; i++) begin
			shadow[0][i] = '0;
			shadow[1][i] = '0;
			lastUsed[i] = 1'b0;
		end
		for (int i = 0; i < 4096; i++) begin
			refMem[i] = memPattern(dcachePkg::word_t'(i * 4));
		end
		repeat (RESET_CYCLES) @(posedge CLK);
		#2;
		nRST = 1'b1;
		@(negedge CLK);
		assert (!dHit && !flushed && !memReq.ren && !memReq.wen)
			else abortRun("Outputs not idle after reset");
		@(posedge CLK);
		#2;
		for (int k = 0; k < CONFLICT_N; k++) begin
			a = '0;
			a.tag = dcachePkg::TAG_W'(conflictTag[k]);
			a.idx = 3'd5;
			a.blkOff = k[0];
			stimState = xorshift(stimState);
			doAccess(a, conflictWr[k], stimState);
		end
		for (int n = 0; n < N_ACCESS; n++) begin
			stimState = xorshift(stimState);
			a = dcachePkg::dAddr_t'((stimState % ADDR_SPAN) & 32'hFFFF_FFFC);
			wr = stimState[16];
			stimState = xorshift(stimState);
			doAccess(a, wr, stimState);
		end
		refFlush();
		halt = 1'b1;
		while (!flushed) @(negedge CLK);
		repeat (4) begin
			@(negedge CLK);
			assert (flushed) else abortRun("flushed dropped after the flush");
		end
		assert (expXfer.size() == 0) else abortRun("Expected memory transfers never happened");
		for (int i = 0; i < 4096; i++) begin
			assert (mem.words[i] == refMem[i]) else begin
				$display("[ERROR] %0t: memory at 0x%08h holds 0x%08h, expected 0x%08h",
					$time, i * 4, mem.words[i], refMem[i]);
				abortRun("Memory differs after the flush");
			end
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== bench/memModel.sv ====
`timescale 1ns/1ps

module memModel (
	input  logic               CLK,
	input  logic               nRST,
	input  dcachePkg::memReq_t req,
	input  logic [1:0]         nextWait,
	output dcachePkg::word_t   load,
	output logic               busy
);

	localparam int DEPTH = 4096;

	dcachePkg::word_t words [DEPTH];
	// Completed transfers as {write, address, data}, oldest first
	logic [64:0] xferLog [$];
	logic [1:0] waitLeft;
	logic [11:0] wordIdx;
	logic active;

	// A different word at every address
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			words[i] <= (dcachePkg::word_t'(i * 4) * 32'h9E3779B1) ^ 32'hC3A55A3C;
		end
	end

	assign active = req.ren || req.wen;
	assign wordIdx = req.addr[13:2];
	assign load = words[wordIdx];
	assign busy = active && (waitLeft != 2'd0);

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			waitLeft <= 2'd0;
		end else if (active) begin
			if (waitLeft == 2'd0) begin
				if (req.wen) begin
					words[wordIdx] <= req.store;
				end
				xferLog.push_back({req.wen, req.addr, req.wen ? req.store : load});
				// Wait of the next transfer
				waitLeft <= nextWait;
			end else begin
				waitLeft <= waitLeft - 2'd1;
			end
		end
	end

endmodule

// ==== src/dcache.sv ====
`timescale 1ns/1ps

module dcache (
	input  logic               CLK,
	input  logic               nRST,
	input  dcachePkg::cpuReq_t cpuReq,
	input  logic               halt,
	output logic               dHit,
	output dcachePkg::word_t   loadData,
	output logic               flushed,
	output dcachePkg::memReq_t memReq,
	input  dcachePkg::word_t   memLoad,
	input  logic               memWait
);

	dcachePkg::cpuReq_t reqSel;
	logic [dcachePkg::IDX_W-1:0] rdIdx;
	logic [dcachePkg::IDX_W-1:0] flushIdx;
	dcachePkg::wayCmd_t cmdZero;
	dcachePkg::wayCmd_t cmdOne;
	dcachePkg::frame_t frameZero;
	dcachePkg::frame_t frameOne;
	logic [dcachePkg::SETS-1:0] dirtyZero;
	logic [dcachePkg::SETS-1:0] dirtyOne;
	logic hitZero;
	logic hitOne;
	logic fillWay;
	logic touch;
	logic touchWay;
	logic found;
	logic flushWay;

	// Flush walks the sets by itself
	assign rdIdx = halt ? flushIdx : cpuReq.addr.idx;
	assign reqSel = dcachePkg::cpuReq_t'({
		cpuReq.ren,
		cpuReq.wen,
		cpuReq.addr.tag,
		rdIdx,
		cpuReq.addr.blkOff,
		cpuReq.addr.bytOff,
		cpuReq.store
	});

	cacheWay wayZero (
		.CLK(CLK), .nRST(nRST), .cmd(cmdZero), .rdIdx(rdIdx), .tag(reqSel.addr.tag),
		.frame(frameZero), .hit(hitZero), .dirtyVec(dirtyZero)
	);

	cacheWay wayOne (
		.CLK(CLK), .nRST(nRST), .cmd(cmdOne), .rdIdx(rdIdx), .tag(reqSel.addr.tag),
		.frame(frameOne), .hit(hitOne), .dirtyVec(dirtyOne)
	);

	victimSelect victimSel (
		.CLK(CLK), .nRST(nRST), .idx(rdIdx),
		.validZero(frameZero.valid), .validOne(frameOne.valid),
		.touch(touch), .touchWay(touchWay), .fillWay(fillWay)
	);

	flushScan scan (
		.dirtyZero(dirtyZero), .dirtyOne(dirtyOne),
		.found(found), .flushWay(flushWay), .flushIdx(flushIdx)
	);

	dcacheController ctrl (
		.CLK(CLK), .nRST(nRST), .cpuReq(reqSel), .halt(halt),
		.hitZero(hitZero), .hitOne(hitOne), .frameZero(frameZero), .frameOne(frameOne),
		.fillWay(fillWay), .found(found), .flushWay(flushWay),
		.memLoad(memLoad), .memWait(memWait),
		.cmdZero(cmdZero), .cmdOne(cmdOne), .touch(touch), .touchWay(touchWay),
		.dHit(dHit), .loadData(loadData), .flushed(flushed), .memReq(memReq)
	);

endmodule

// ==== src/dcacheController.sv ====
`timescale 1ns/1ps

module dcacheController (
	input  logic                  CLK,
	input  logic                  nRST,
	input  dcachePkg::cpuReq_t    cpuReq,
	input  logic                  halt,
	input  logic                  hitZero,
	input  logic                  hitOne,
	input  dcachePkg::frame_t     frameZero,
	input  dcachePkg::frame_t     frameOne,
	input  logic                  fillWay,
	input  logic                  found,
	input  logic                  flushWay,
	input  dcachePkg::word_t      memLoad,
	input  logic                  memWait,
	output dcachePkg::wayCmd_t    cmdZero,
	output dcachePkg::wayCmd_t    cmdOne,
	output logic                  touch,
	output logic                  touchWay,
	output logic                  dHit,
	output dcachePkg::word_t      loadData,
	output logic                  flushed,
	output dcachePkg::memReq_t    memReq
);

	dcachePkg::cacheState_t state;
	dcachePkg::cacheState_t nextState;
	dcachePkg::word_t hitCount;
	dcachePkg::word_t missCount;
	dcachePkg::frame_t hitFrame;
	dcachePkg::frame_t victim;
	dcachePkg::word_t wbAddr;
	dcachePkg::word_t fillAddr;
	dcachePkg::wayCmd_t cmd;
	logic hitWay;
	logic victimWay;
	logic cmdWay;
	logic anyReq;

	// Drops the enables of a command meant for the other way
	function automatic dcachePkg::wayCmd_t gateCmd(
		input dcachePkg::wayCmd_t c,
		input logic en
	);
		dcachePkg::wayCmd_t g;
		g = c;
		if (!en) begin
			g.fillA = 1'b0;
			g.fillB = 1'b0;
			g.store = 1'b0;
			g.clean = 1'b0;
			g.touchTag = 1'b0;
		end
		return g;
	endfunction

	assign anyReq = cpuReq.ren || cpuReq.wen;
	assign hitWay = !hitZero && hitOne;
	assign hitFrame = hitWay ? frameOne : frameZero;

	// During a flush the scanner picks the frame
	assign victimWay = halt ? flushWay : fillWay;
	assign victim = victimWay ? frameOne : frameZero;

	assign wbAddr = {victim.tag, cpuReq.addr.idx, 3'b000};
	assign fillAddr = {cpuReq.addr.tag, cpuReq.addr.idx, 3'b000};

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= dcachePkg::IDLE;
		end else begin
			state <= nextState;
		end
	end

	// Every access ends in a hit state, so hits minus misses gives real hits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			hitCount <= '0;
			missCount <= '0;
		end else begin
			if (state == dcachePkg::READHIT || state == dcachePkg::WRITEHIT) begin
				hitCount <= hitCount + 1'b1;
			end
			if (state == dcachePkg::FILLA && !memWait) begin
				missCount <= missCount + 1'b1;
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			dcachePkg::IDLE: begin
				if (halt) begin
					nextState = dcachePkg::FLUSH;
				end else if (anyReq && (hitZero || hitOne)) begin
					nextState = cpuReq.ren ? dcachePkg::READHIT : dcachePkg::OVERWRITE;
				end else if (anyReq) begin
					nextState = victim.dirty ? dcachePkg::WBA : dcachePkg::FILLA;
				end
			end
			dcachePkg::READHIT:   nextState = dcachePkg::IDLE;
			dcachePkg::OVERWRITE: nextState = dcachePkg::WRITEHIT;
			dcachePkg::WRITEHIT:  nextState = dcachePkg::IDLE;
			dcachePkg::WBA: begin
				if (!memWait) begin
					nextState = dcachePkg::WBB;
				end
			end
			dcachePkg::WBB: begin
				if (!memWait) begin
					nextState = halt ? dcachePkg::FLUSH : dcachePkg::FILLA;
				end
			end
			dcachePkg::FILLA: begin
				if (!memWait) begin
					nextState = dcachePkg::FILLB;
				end
			end
			dcachePkg::FILLB: begin
				// A read goes back and hits on the fresh block
				if (!memWait) begin
					nextState = cpuReq.wen ? dcachePkg::OVERWRITE : dcachePkg::IDLE;
				end
			end
			dcachePkg::FLUSH: nextState = found ? dcachePkg::WBA : dcachePkg::STATS;
			dcachePkg::STATS: begin
				if (!memWait) begin
					nextState = dcachePkg::STOP;
				end
			end
			default: nextState = dcachePkg::STOP;
		endcase
	end

	// Memory port
	always_comb begin
		memReq = '0;
		case (state)
			dcachePkg::WBA: begin
				memReq.wen = 1'b1;
				memReq.addr = wbAddr;
				memReq.store = victim.data.wordA;
			end
			dcachePkg::WBB: begin
				memReq.wen = 1'b1;
				memReq.addr = wbAddr + dcachePkg::WORD_BYTES;
				memReq.store = victim.data.wordB;
			end
			dcachePkg::FILLA: begin
				memReq.ren = 1'b1;
				memReq.addr = fillAddr;
			end
			dcachePkg::FILLB: begin
				memReq.ren = 1'b1;
				memReq.addr = fillAddr + dcachePkg::WORD_BYTES;
			end
			dcachePkg::STATS: begin
				memReq.wen = 1'b1;
				memReq.addr = dcachePkg::STATS_ADDR;
				memReq.store = hitCount - missCount;
			end
			default: memReq = '0;
		endcase
	end

	// Way commands, applied only when a memory word completes
	always_comb begin
		cmd = '0;
		cmd.idx = cpuReq.addr.idx;
		cmd.tag = cpuReq.addr.tag;
		cmd.wordSel = cpuReq.addr.blkOff;
		cmd.data = memLoad;
		cmdWay = victimWay;
		case (state)
			dcachePkg::WBB: cmd.clean = !memWait;
			dcachePkg::FILLA: begin
				cmd.fillA = !memWait;
				cmd.touchTag = !memWait;
			end
			dcachePkg::FILLB: cmd.fillB = !memWait;
			dcachePkg::OVERWRITE: begin
				cmd.store = 1'b1;
				cmd.data = cpuReq.store;
				cmdWay = hitWay;
			end
			default: cmdWay = victimWay;
		endcase
	end

	assign cmdZero = gateCmd(cmd, !cmdWay);
	assign cmdOne = gateCmd(cmd, cmdWay);

	assign dHit = (state == dcachePkg::READHIT) || (state == dcachePkg::WRITEHIT);
	assign touch = dHit;
	assign touchWay = hitWay;
	assign loadData = cpuReq.addr.blkOff ? hitFrame.data.wordB : hitFrame.data.wordA;
	assign flushed = (state == dcachePkg::STOP);

endmodule

// ==== src/flushScan.sv ====
`timescale 1ns/1ps

module flushScan (
	input  logic [dcachePkg::SETS-1:0]  dirtyZero,
	input  logic [dcachePkg::SETS-1:0]  dirtyOne,
	output logic                        found,
	output logic                        flushWay,
	output logic [dcachePkg::IDX_W-1:0] flushIdx
);

	// Walk downward so the lowest dirty index wins, way 0 over way 1
	always_comb begin
		flushWay = 1'b0;
		flushIdx = '0;
		for (int i = dcachePkg::SETS - 1; i >= 0; i--) begin
			if (dirtyOne[i]) begin
				flushWay = 1'b1;
				flushIdx = dcachePkg::IDX_W'(i);
			end
		end
		for (int i = dcachePkg::SETS - 1; i >= 0; i--) begin
			if (dirtyZero[i]) begin
				flushWay = 1'b0;
				flushIdx = dcachePkg::IDX_W'(i);
			end
		end
	end

	assign found = (|dirtyZero) || (|dirtyOne);

endmodule

// ==== src/victimSelect.sv ====
`timescale 1ns/1ps

module victimSelect (
	input  logic                        CLK,
	input  logic                        nRST,
	input  logic [dcachePkg::IDX_W-1:0] idx,
	input  logic                        validZero,
	input  logic                        validOne,
	input  logic                        touch,
	input  logic                        touchWay,
	output logic                        fillWay
);

	// Way used last, one bit per set
	logic [dcachePkg::SETS-1:0] recUsed;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			recUsed <= '0;
		end else if (touch) begin
			recUsed[idx] <= touchWay;
		end
	end

	// Empty frames first, then the older way
	always_comb begin
		if (!validZero) begin
			fillWay = 1'b0;
		end else if (!validOne) begin
			fillWay = 1'b1;
		end else begin
			fillWay = !recUsed[idx];
		end
	end

endmodule

// ==== src/cacheWay.sv ====
`timescale 1ns/1ps

module cacheWay (
	input  logic                             CLK,
	input  logic                             nRST,
	input  dcachePkg::wayCmd_t               cmd,
	input  logic [dcachePkg::IDX_W-1:0]      rdIdx,
	input  logic [dcachePkg::TAG_W-1:0]      tag,
	output dcachePkg::frame_t                frame,
	output logic                             hit,
	output logic [dcachePkg::SETS-1:0]       dirtyVec
);

	logic [dcachePkg::TAG_W-1:0] tagMem [dcachePkg::SETS];
	dcachePkg::block_t dataMem [dcachePkg::SETS];
	logic [dcachePkg::SETS-1:0] validVec;

	// Status bits per frame
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			validVec <= '0;
			dirtyVec <= '0;
		end else begin
			// New tag makes the frame unusable until word B lands
			if (cmd.touchTag) begin
				validVec[cmd.idx] <= 1'b0;
			end
			if (cmd.fillB) begin
				validVec[cmd.idx] <= 1'b1;
				dirtyVec[cmd.idx] <= 1'b0;
			end
			if (cmd.clean) begin
				dirtyVec[cmd.idx] <= 1'b0;
			end
			if (cmd.store) begin
				dirtyVec[cmd.idx] <= 1'b1;
			end
		end
	end

	// Tag and data storage
	always_ff @(posedge CLK) begin
		if (cmd.touchTag) begin
			tagMem[cmd.idx] <= cmd.tag;
		end
		if (cmd.fillA) begin
			dataMem[cmd.idx].wordA <= cmd.data;
		end
		if (cmd.fillB) begin
			dataMem[cmd.idx].wordB <= cmd.data;
		end
		if (cmd.store) begin
			if (cmd.wordSel) begin
				dataMem[cmd.idx].wordB <= cmd.data;
			end else begin
				dataMem[cmd.idx].wordA <= cmd.data;
			end
		end
	end

	// Combinational read at the request index
	assign frame = '{
		tag:   tagMem[rdIdx],
		data:  dataMem[rdIdx],
		valid: validVec[rdIdx],
		dirty: dirtyVec[rdIdx]
	};

	assign hit = frame.valid && (frame.tag == tag);

endmodule

// ==== src/dcachePkg.sv ====
package dcachePkg;

	// Geometry
	localparam int WORD_W = 32;
	localparam int SETS = 8;
	localparam int IDX_W = 3;
	localparam int TAG_W = 26;
	localparam int WORD_BYTES = 4;

	// Where the flush leaves hits minus misses
	localparam logic [WORD_W-1:0] STATS_ADDR = 32'h00003100;

	typedef logic [WORD_W-1:0] word_t;

	// Byte address as seen by the cache
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic             blkOff;
		logic [1:0]       bytOff;
	} dAddr_t;

	typedef struct packed {
		word_t wordA;
		word_t wordB;
	} block_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		block_t           data;
		logic             valid;
		logic             dirty;
	} frame_t;

	typedef struct packed {
		logic   ren;
		logic   wen;
		dAddr_t addr;
		word_t  store;
	} cpuReq_t;

	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} memReq_t;

	// One write command per way and cycle
	typedef struct packed {
		logic             fillA;
		logic             fillB;
		logic             store;
		logic             clean;
		logic             touchTag;
		logic [IDX_W-1:0] idx;
		logic [TAG_W-1:0] tag;
		logic             wordSel;
		word_t            data;
	} wayCmd_t;

	typedef enum logic [3:0] {
		IDLE      = 4'h0,
		READHIT   = 4'h1,
		OVERWRITE = 4'h2,
		WRITEHIT  = 4'h3,
		WBA       = 4'h4,
		WBB       = 4'h5,
		FILLA     = 4'h6,
		FILLB     = 4'h7,
		FLUSH     = 4'h8,
		STATS     = 4'h9,
		STOP      = 4'hA
	} cacheState_t;

endpackage
